/* hw/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  // axi4-lite field widths
  parameter int AXI_ADDR_W = 32;
  parameter int AXI_DATA_W = 32;
  parameter int AXI_STRB_W = AXI_DATA_W / 8;
  parameter int AXI_RESP_W = 2;

  parameter logic [AXI_RESP_W-1:0] AXI_RESP_OKAY = 2'b00;

  // cacheable main memory
  parameter logic [31:0] DRAM_BASE = 32'h8000_0000;
  parameter logic [31:0] DRAM_SIZE = 32'h0000_0400;

  // uncached device window
  parameter logic [31:0] IO_BASE = 32'h1000_0000;
  parameter logic [31:0] IO_SIZE = 32'h0000_0040;

  // controller states
  typedef enum logic [2:0] {
    HIT_CMP,
    SEND_DATA,
    WAIT_WRITING,
    SEND_ADDR,
    WAIT_DATA,
    FINISH
  } cache_state_t;

endpackage

`default_nettype wire

/* hw/direct_map.sv */
`timescale 1ns/1ns
`default_nettype none

module direct_map #(
  parameter int LINES = 16
) (
  input  logic        clk,
  input  logic        reset,

  // lookup address, held by the cpu for the whole access
  input  logic [31:0] addr,

  input  logic        write_valid,
  input  logic [31:0] write_data,
  input  logic [3:0]  write_strb,
  input  logic        set_dirty,

  output logic        hit,
  output logic        dirty,
  output logic [31:0] data,
  output logic [31:0] victim_addr
);

  localparam int INDEX_W = $clog2(LINES);
  localparam int TAG_W   = 30 - INDEX_W;

  logic [TAG_W-1:0]   tag_mem  [LINES];
  logic [31:0]        data_mem [LINES];
  logic [LINES-1:0]   valid_q;
  logic [LINES-1:0]   dirty_q;

  logic [INDEX_W-1:0] index;
  logic [TAG_W-1:0]   tag;

  // word offset bits [1:0] select nothing, one word per line
  assign index = addr[INDEX_W+1:2];
  assign tag   = addr[31:INDEX_W+2];

  assign hit   = valid_q[index] && (tag_mem[index] == tag);
  assign dirty = valid_q[index] && dirty_q[index];
  assign data  = data_mem[index];

  // where the resident line lives in memory
  assign victim_addr = {tag_mem[index], index, 2'b00};

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (write_valid) begin
      valid_q[index] <= 1'b1;
      dirty_q[index] <= set_dirty;
    end
  end

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (write_valid) begin
      tag_mem[index] <= tag;
      for (int b = 0; b < 4; b++) begin
        if (write_strb[b]) begin
          data_mem[index][8*b +: 8] <= write_data[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/d_cache.sv */
`timescale 1ns/1ns
`default_nettype none

module d_cache #(
  parameter int LINES = 16
) (
  input  logic        clk,
  input  logic        reset,

  // cpu side
  input  logic [31:0] addr,
  input  logic        mem_wen,
  input  logic        mem_ren,
  input  logic [31:0] data_in,
  input  logic [3:0]  data_in_strb,
  output logic [31:0] data_out,
  output logic        data_read_valid,
  output logic        data_write_ready,

  // axi4-lite read channels
  output logic                                  arvalid,
  input  logic                                  arready,
  output logic [dcache_pkg::AXI_ADDR_W-1:0]     araddr,
  input  logic                                  rvalid,
  output logic                                  rready,
  input  logic [dcache_pkg::AXI_DATA_W-1:0]     rdata,
  input  logic [dcache_pkg::AXI_RESP_W-1:0]     rresp,

  // axi4-lite write channels
  output logic [dcache_pkg::AXI_ADDR_W-1:0]     awaddr,
  output logic                                  awvalid,
  input  logic                                  awready,
  output logic [dcache_pkg::AXI_DATA_W-1:0]     wdata,
  output logic [dcache_pkg::AXI_STRB_W-1:0]     wstrb,
  output logic                                  wvalid,
  input  logic                                  wready,
  input  logic [dcache_pkg::AXI_RESP_W-1:0]     bresp,
  input  logic                                  bvalid,
  output logic                                  bready,

  // line storage
  input  logic        hit,
  input  logic        dirty,
  input  logic [31:0] line_data,
  input  logic [31:0] victim_addr,
  output logic        cache_wen,
  output logic [31:0] cache_wdata,
  output logic [3:0]  cache_wstrb,
  output logic        cache_set_dirty
);

  localparam int LINE_COUNT_CHECK = LINES;

  dcache_pkg::cache_state_t state;

  logic cacheable;
  logic request;
  logic rresp_ok;
  logic bresp_ok;

  assign cacheable = (addr - dcache_pkg::DRAM_BASE) < dcache_pkg::DRAM_SIZE;
  assign request   = mem_ren || mem_wen;
  assign rresp_ok  = rresp == dcache_pkg::AXI_RESP_OKAY;
  assign bresp_ok  = bresp == dcache_pkg::AXI_RESP_OKAY;

  // handshake outputs follow the state directly
  assign arvalid = state == dcache_pkg::SEND_ADDR;
  assign rready  = state == dcache_pkg::WAIT_DATA;
  assign awvalid = state == dcache_pkg::SEND_DATA;
  assign wvalid  = state == dcache_pkg::SEND_DATA;
  assign bready  = state == dcache_pkg::WAIT_WRITING;

  // line writes: store hit or refill
  always_comb begin
    cache_wen       = 1'b0;
    cache_wdata     = rdata;
    cache_wstrb     = 4'hF;
    cache_set_dirty = 1'b0;
    if (state == dcache_pkg::HIT_CMP && cacheable && hit && mem_wen) begin
      cache_wen       = 1'b1;
      cache_wdata     = data_in;
      cache_wstrb     = data_in_strb;
      cache_set_dirty = 1'b1;
    end else if (state == dcache_pkg::WAIT_DATA && cacheable && rvalid && rresp_ok) begin
      // refill lands clean
      cache_wen = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state            <= dcache_pkg::HIT_CMP;
      data_read_valid  <= 1'b0;
      data_write_ready <= 1'b0;
    end else begin
      data_read_valid  <= 1'b0;
      data_write_ready <= 1'b0;
      case (state)
        dcache_pkg::HIT_CMP: begin
          if (request) begin
            if (cacheable && hit) begin
              state            <= dcache_pkg::FINISH;
              data_read_valid  <= mem_ren;
              data_write_ready <= mem_wen;
            end else if (cacheable && dirty) begin
              // victim goes out before the refill
              state <= dcache_pkg::SEND_DATA;
            end else if (!cacheable && mem_wen) begin
              state <= dcache_pkg::SEND_DATA;
            end else begin
              state <= dcache_pkg::SEND_ADDR;
            end
          end
        end
        dcache_pkg::SEND_DATA: begin
          if (awready && wready) begin
            state <= dcache_pkg::WAIT_WRITING;
          end
        end
        dcache_pkg::WAIT_WRITING: begin
          if (bvalid) begin
            if (!cacheable) begin
              state            <= dcache_pkg::FINISH;
              data_write_ready <= 1'b1;
            end else if (bresp_ok) begin
              state <= dcache_pkg::SEND_ADDR;
            end else begin
              // failed write-back is retried from the lookup
              state <= dcache_pkg::HIT_CMP;
            end
          end
        end
        dcache_pkg::SEND_ADDR: begin
          if (arready) begin
            state <= dcache_pkg::WAIT_DATA;
          end
        end
        dcache_pkg::WAIT_DATA: begin
          if (rvalid) begin
            if (cacheable && mem_wen) begin
              // store merges on the hit path next cycle
              state <= dcache_pkg::HIT_CMP;
            end else begin
              state           <= dcache_pkg::FINISH;
              data_read_valid <= 1'b1;
            end
          end
        end
        dcache_pkg::FINISH: begin
          state <= dcache_pkg::HIT_CMP;
        end
        default: begin
          state <= dcache_pkg::HIT_CMP;
        end
      endcase
    end
  end

  // bus payload and read data
  always_ff @(posedge clk) begin
    if (state == dcache_pkg::HIT_CMP && request) begin
      araddr <= addr;
      if (cacheable && hit) begin
        data_out <= line_data;
      end
      if (cacheable && !hit && dirty) begin
        awaddr <= victim_addr;
        wdata  <= line_data;
        wstrb  <= 4'hF;
      end else begin
        awaddr <= addr;
        wdata  <= data_in;
        wstrb  <= data_in_strb;
      end
    end
    if (state == dcache_pkg::WAIT_DATA && rvalid) begin
      data_out <= rdata;
    end
  end

  initial begin
    if (LINE_COUNT_CHECK < 2 || (LINE_COUNT_CHECK & (LINE_COUNT_CHECK - 1)) != 0) begin
      $error("d_cache: LINES must be a power of two, at least 2");
    end
  end

endmodule

`default_nettype wire

/* hw/axi_lite_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_lite_ram #(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 3
) (
  input  logic                              clk,
  input  logic                              reset,

  input  logic [dcache_pkg::AXI_ADDR_W-1:0] araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [dcache_pkg::AXI_DATA_W-1:0] rdata,
  output logic [dcache_pkg::AXI_RESP_W-1:0] rresp,
  output logic                              rvalid,
  input  logic                              rready,

  input  logic [dcache_pkg::AXI_ADDR_W-1:0] awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [dcache_pkg::AXI_DATA_W-1:0] wdata,
  input  logic [dcache_pkg::AXI_STRB_W-1:0] wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [dcache_pkg::AXI_RESP_W-1:0] bresp,
  output logic                              bvalid,
  input  logic                              bready
);

  localparam int IDX_W = $clog2(RAM_WORDS);
  localparam int CNT_W = $clog2(RAM_LATENCY + 1);

  logic [31:0]      dram_mem [RAM_WORDS];
  logic [31:0]      io_mem   [RAM_WORDS];

  logic             busy;
  logic             is_read;
  logic [CNT_W-1:0] cnt;
  logic [31:0]      rd_addr;
  logic [31:0]      rd_word;
  logic             rd_accept;
  logic             wr_accept;
  logic             respond;
  logic             wr_in_io;
  logic             wr_in_dram;
  logic [IDX_W-1:0] wr_io_idx;
  logic [IDX_W-1:0] wr_dram_idx;

  assign arready   = !busy;
  assign awready   = !busy;
  assign wready    = awready;
  assign rd_accept = arvalid && arready;
  assign wr_accept = awvalid && wvalid && awready && wready;
  assign respond   = busy && !rvalid && !bvalid && (cnt == '0);

  assign rresp = dcache_pkg::AXI_RESP_OKAY;
  assign bresp = dcache_pkg::AXI_RESP_OKAY;

  // bank select and word index, modulo the bank size
  assign wr_in_io    = (awaddr - dcache_pkg::IO_BASE) < dcache_pkg::IO_SIZE;
  assign wr_in_dram  = (awaddr - dcache_pkg::DRAM_BASE) < dcache_pkg::DRAM_SIZE;
  assign wr_io_idx   = IDX_W'((awaddr - dcache_pkg::IO_BASE) >> 2);
  assign wr_dram_idx = IDX_W'((awaddr - dcache_pkg::DRAM_BASE) >> 2);

  always_comb begin
    rd_word = '0;
    if ((rd_addr - dcache_pkg::IO_BASE) < dcache_pkg::IO_SIZE) begin
      rd_word = io_mem[IDX_W'((rd_addr - dcache_pkg::IO_BASE) >> 2)];
    end else if ((rd_addr - dcache_pkg::DRAM_BASE) < dcache_pkg::DRAM_SIZE) begin
      rd_word = dram_mem[IDX_W'((rd_addr - dcache_pkg::DRAM_BASE) >> 2)];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      is_read <= 1'b0;
      cnt     <= '0;
      rvalid  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      if (rd_accept || wr_accept) begin
        busy    <= 1'b1;
        is_read <= rd_accept;
        cnt     <= CNT_W'(RAM_LATENCY - 1);
      end else if (respond) begin
        rvalid <= is_read;
        bvalid <= !is_read;
      end else if (busy && !rvalid && !bvalid) begin
        cnt <= cnt - 1'b1;
      end
      // response held until taken
      if ((rvalid && rready) || (bvalid && bready)) begin
        rvalid <= 1'b0;
        bvalid <= 1'b0;
        busy   <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rd_addr <= araddr;
    end
    if (respond && is_read) begin
      rdata <= rd_word;
    end
  end

  // banks start zeroed
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        dram_mem[i] <= '0;
        io_mem[i]   <= '0;
      end
    end else if (wr_accept) begin
      for (int b = 0; b < dcache_pkg::AXI_STRB_W; b++) begin
        if (wstrb[b] && wr_in_io) begin
          io_mem[wr_io_idx][8*b +: 8] <= wdata[8*b +: 8];
        end else if (wstrb[b] && wr_in_dram) begin
          dram_mem[wr_dram_idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_top #(
  parameter int LINES       = 16,
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 3
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] addr,
  input  logic        mem_wen,
  input  logic        mem_ren,
  input  logic [31:0] data_in,
  input  logic [3:0]  data_in_strb,
  output logic [31:0] data_out,
  output logic        data_read_valid,
  output logic        data_write_ready
);

  // cache to storage
  logic        hit;
  logic        dirty;
  logic [31:0] line_data;
  logic [31:0] victim_addr;
  logic        cache_wen;
  logic [31:0] cache_wdata;
  logic [3:0]  cache_wstrb;
  logic        cache_set_dirty;

  // axi4-lite
  logic                              arvalid;
  logic                              arready;
  logic [dcache_pkg::AXI_ADDR_W-1:0] araddr;
  logic                              rvalid;
  logic                              rready;
  logic [dcache_pkg::AXI_DATA_W-1:0] rdata;
  logic [dcache_pkg::AXI_RESP_W-1:0] rresp;
  logic [dcache_pkg::AXI_ADDR_W-1:0] awaddr;
  logic                              awvalid;
  logic                              awready;
  logic [dcache_pkg::AXI_DATA_W-1:0] wdata;
  logic [dcache_pkg::AXI_STRB_W-1:0] wstrb;
  logic                              wvalid;
  logic                              wready;
  logic [dcache_pkg::AXI_RESP_W-1:0] bresp;
  logic                              bvalid;
  logic                              bready;

  d_cache #(
    .LINES(LINES)
  ) u_cache (
    .clk, .reset, .addr, .mem_wen, .mem_ren, .data_in, .data_in_strb,
    .data_out, .data_read_valid, .data_write_ready,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .hit, .dirty, .line_data, .victim_addr,
    .cache_wen, .cache_wdata, .cache_wstrb, .cache_set_dirty
  );

  direct_map #(
    .LINES(LINES)
  ) u_map (
    .clk,
    .reset,
    .addr,
    .write_valid (cache_wen),
    .write_data  (cache_wdata),
    .write_strb  (cache_wstrb),
    .set_dirty   (cache_set_dirty),
    .hit,
    .dirty,
    .data        (line_data),
    .victim_addr
  );

  axi_lite_ram #(
    .RAM_WORDS   (RAM_WORDS),
    .RAM_LATENCY (RAM_LATENCY)
  ) u_ram (
    .clk, .reset,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready
  );

endmodule

`default_nettype wire

/* tb/dcache_properties.sv */
`timescale 1ns/1ns

module dcache_properties (
  input logic                              clk,
  input logic                              reset,
  input dcache_pkg::cache_state_t          state,
  input logic                              arvalid,
  input logic                              arready,
  input logic [dcache_pkg::AXI_ADDR_W-1:0] araddr,
  input logic                              awvalid,
  input logic                              awready,
  input logic [dcache_pkg::AXI_ADDR_W-1:0] awaddr,
  input logic                              wvalid,
  input logic                              wready,
  input logic                              data_read_valid,
  input logic                              data_write_ready
);

  ar_hold: assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid dropped or araddr moved before arready");

  // address and data beats stay paired until both are taken
  aw_w_hold: assert property (@(posedge clk) disable iff (reset)
    (awvalid || wvalid) && !(awready && wready) |=>
      awvalid && wvalid && $stable(awaddr))
    else $error("awvalid or wvalid dropped or awaddr moved before awready and wready");

  one_completion: assert property (@(posedge clk) disable iff (reset)
    !(data_read_valid && data_write_ready))
    else $error("read and write completion in the same cycle");

  // pulses only from FINISH, which always leaves after one cycle
  pulse_in_finish: assert property (@(posedge clk) disable iff (reset)
    (data_read_valid || data_write_ready) |-> state == dcache_pkg::FINISH)
    else $error("completion pulse outside FINISH");

  read_pulse_short: assert property (@(posedge clk) disable iff (reset)
    data_read_valid |=> !data_read_valid)
    else $error("data_read_valid held longer than one cycle");

  write_pulse_short: assert property (@(posedge clk) disable iff (reset)
    data_write_ready |=> !data_write_ready)
    else $error("data_write_ready held longer than one cycle");

endmodule

bind d_cache dcache_properties u_props (
  .clk              (clk),
  .reset            (reset),
  .state            (state),
  .arvalid          (arvalid),
  .arready          (arready),
  .araddr           (araddr),
  .awvalid          (awvalid),
  .awready          (awready),
  .awaddr           (awaddr),
  .wvalid           (wvalid),
  .wready           (wready),
  .data_read_valid  (data_read_valid),
  .data_write_ready (data_write_ready)
);

/* tb/dcache_tb.sv */
`timescale 1ns/1ns

module dcache_tb;

  localparam int TIMEOUT    = 200;
  localparam int RANDOM_OPS = 2000;

  logic        clk;
  logic        reset;
  logic [31:0] addr;
  logic        mem_wen;
  logic        mem_ren;
  logic [31:0] data_in;
  logic [3:0]  data_in_strb;
  logic [31:0] data_out;
  logic        data_read_valid;
  logic        data_write_ready;

  // expected memory, keyed by word address, absent words read as zero
  logic [31:0] model [logic [31:0]];

  int data_errors;
  int timeout_errors;

  dcache_top #(
    .LINES       (16),
    .RAM_WORDS   (256),
    .RAM_LATENCY (3)
  ) uut (
    .clk, .reset, .addr, .mem_wen, .mem_ren, .data_in, .data_in_strb,
    .data_out, .data_read_valid, .data_write_ready
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] model_word(input logic [31:0] a);
    if (model.exists(a >> 2)) begin
      return model[a >> 2];
    end
    return 32'h0;
  endfunction

  function automatic void model_write(input logic [31:0] a, input logic [31:0] d,
                                      input logic [3:0] strb);
    logic [31:0] w;
    w = model_word(a);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        w[8*b +: 8] = d[8*b +: 8];
      end
    end
    model[a >> 2] = w;
  endfunction

  // 48 dram words alias three deep over 16 lines
  function automatic logic [31:0] random_addr();
    if ($urandom % 4 == 0) begin
      return dcache_pkg::IO_BASE + 4 * ($urandom % 8);
    end
    return dcache_pkg::DRAM_BASE + 4 * ($urandom % 48);
  endfunction

  // outputs sampled on the falling edge, away from the dut update
  task automatic wait_done(input string name, input logic is_write, output int cycles);
    logic seen;
    cycles = 0;
    @(negedge clk);
    seen = is_write ? data_write_ready : data_read_valid;
    while (!seen && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      seen = is_write ? data_write_ready : data_read_valid;
    end
    assert (seen) else begin
      $display("%s: access to %h never completed within %0d cycles", name, addr, TIMEOUT);
      timeout_errors++;
    end
  endtask

  task automatic do_read(input string name, input logic [31:0] a,
                         output logic [31:0] got, output int lat);
    @(posedge clk);
    addr    <= a;
    mem_ren <= 1'b1;
    wait_done(name, 1'b0, lat);
    got = data_out;
    @(posedge clk);
    mem_ren <= 1'b0;
  endtask

  task automatic do_write(input string name, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] strb, output int lat);
    @(posedge clk);
    addr         <= a;
    data_in      <= d;
    data_in_strb <= strb;
    mem_wen      <= 1'b1;
    wait_done(name, 1'b1, lat);
    model_write(a, d, strb);
    @(posedge clk);
    mem_wen <= 1'b0;
  endtask

  task automatic check_read(input string name, input logic [31:0] a, output int lat);
    logic [31:0] got;
    logic [31:0] exp;
    exp = model_word(a);
    do_read(name, a, got, lat);
    assert (got === exp) else begin
      $display("FAIL %s: addr %h expected %h actual %h", name, a, exp, got);
      data_errors++;
    end
  endtask

  task automatic check_latency(input string name, input int lat, input logic want_hit);
    logic ok;
    ok = want_hit ? (lat == 1) : (lat > 1);
    assert (ok) else begin
      $display("FAIL %s: expected latency %s actual %0d", name,
               want_hit ? "1" : "above 1", lat);
      data_errors++;
    end
  endtask

  initial begin
    int          lat;
    logic [31:0] a;
    void'($urandom(32'h3bf6a68b));
    data_errors    = 0;
    timeout_errors = 0;
    reset          = 1'b1;
    addr           = 32'h0;
    mem_wen        = 1'b0;
    mem_ren        = 1'b0;
    data_in        = 32'h0;
    data_in_strb   = 4'h0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // quiet outputs while idle
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      assert (!data_read_valid && !data_write_ready) else begin
        $display("FAIL idle_after_reset: expected 00 actual %b%b",
                 data_read_valid, data_write_ready);
        data_errors++;
      end
    end

    // 0x10 and 0x50 share line 4
    do_write("evict_write_a", dcache_pkg::DRAM_BASE + 32'h10, 32'h1111_aaaa, 4'hF, lat);
    do_write("evict_write_b", dcache_pkg::DRAM_BASE + 32'h50, 32'h2222_bbbb, 4'hF, lat);
    check_read("evict_read_a", dcache_pkg::DRAM_BASE + 32'h10, lat);
    check_read("evict_read_b", dcache_pkg::DRAM_BASE + 32'h50, lat);

    a = dcache_pkg::DRAM_BASE + 32'h28;
    check_read("hit_first_read", a, lat);
    check_read("hit_second_read", a, lat);
    check_latency("hit_second_read", lat, 1'b1);
    do_write("hit_write", a, 32'h5a5a_0f0f, 4'b0110, lat);
    check_latency("hit_write", lat, 1'b1);
    check_read("hit_read_back", a, lat);

    a = dcache_pkg::IO_BASE + 32'hC;
    do_write("io_write", a, 32'hcafe_f00d, 4'hF, lat);
    check_read("io_read_first", a, lat);
    check_latency("io_read_first", lat, 1'b0);
    check_read("io_read_second", a, lat);
    check_latency("io_read_second", lat, 1'b0);

    for (int n = 0; n < RANDOM_OPS; n++) begin
      a = random_addr();
      if ($urandom % 2 == 1) begin
        do_write("random_write", a, $urandom, 4'($urandom), lat);
      end else begin
        check_read("random_read", a, lat);
      end
    end

    $display("checks done: %0d data errors, %0d timeouts", data_errors, timeout_errors);
    if (data_errors == 0 && timeout_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* dcache.f */
hw/dcache_pkg.sv
hw/direct_map.sv
hw/d_cache.sv
hw/axi_lite_ram.sv
hw/dcache_top.sv
tb/dcache_properties.sv
tb/dcache_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= dcache_tb
RTL_TOP    ?= dcache_top
FILELIST   ?= dcache.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
